// File: testbench/aes256_tests.txt
// name (8 ASCII chars as hex) and key, then on the next line
// plaintext, expected ciphertext and idle cycles before the block.
666970735f313937 000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f
00112233445566778899aabbccddeeff 8ea2b7ca516745bfeafc49904b496089 2
6563623235365f31 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4
6bc1bee22e409f96e93d7e117393172a f3eed1bdb5d2a03c064b5a7e3db181f8 0
6563623235365f32 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4
ae2d8a571e03ac9c9eb76fac45af8e51 591ccb10d410ed26dc5ba74a31362870 0
6563623235365f33 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4
30c81c46a35ce411e5fbc1191a0a52ef b6ed21b99ca6f4f9f153e7b1beafed1d 0
6563623235365f34 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4
f69f2445df4f9b17ad2b417be66c3710 23304b7a39f9f3ff067d8d8f9e24ecc7 0
7a65726f5f6b6579 0000000000000000000000000000000000000000000000000000000000000000
00000000000000000000000000000000 dc95c078a2408989ad48a21492842087 3
6b65795f6d736231 8000000000000000000000000000000000000000000000000000000000000000
00000000000000000000000000000000 e35a6dcb19b201a01ebcfa8aa22b5759 0
676673626f785f30 0000000000000000000000000000000000000000000000000000000000000000
014730f80ac625fe84f026c60bfd547d 5c9d844ed46f9885085e5d6a4f94c7d7 5

// File: flist.f
+incdir+design
design/aes_pkg.sv
design/aes_sbox.sv
design/aes_key_step.sv
design/aes_round.sv
design/aes_final_round.sv
design/aes256_core.sv
testbench/aes256_chk.sv
testbench/aes256_tb.sv

// File: run.sh
#!/bin/sh
# build and run the AES-256 testbench with Verilator from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module aes256_tb -f flist.f
./obj_dir/Vaes256_tb +verilator+error+limit+1000 | tee sim.log

if grep -q "No errors" sim.log
then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: testbench/aes256_tb.sv
/* Self-checking testbench for aes256_core; run it from the project root.
   Records come from testbench/aes256_tests.txt and results are matched in order. */
`timescale 1ns/1ps
`include "aes_params.svh"

module aes256_tb;
    import aes_pkg::*;

    localparam int MAX_RECORDS   = 32;
    localparam int REC_WORDS     = 5;
    localparam int EXTRA_GAP_MAX = 3;
    localparam int RESET_CYCLES  = 3;
    localparam int IDLE_CYCLES   = `AES_LATENCY + 11;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    aes_block_t plaintext;
    aes_key_t   key;
    logic       out_valid;
    aes_block_t ciphertext;

    // one record is name, key, plaintext, ciphertext, gap.
    aes_key_t    rec_mem [0:MAX_RECORDS*REC_WORDS-1];
    int          num_records = 0;
    int          max_gap = 0;
    bit          loaded = 1'b0;

    logic [63:0] exp_name [$];
    aes_block_t  exp_ct [$];
    int          exp_cyc [$];

    int cyc = 0;
    int errors = 0;
    int results = 0;
    int tests_run = 0;
    int tests_failed = 0;

    aes256_core dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .plaintext  (plaintext),
        .key        (key),
        .out_valid  (out_valid),
        .ciphertext (ciphertext)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers.
    task automatic check_value(input logic [63:0] name, input string what,
                               input aes_block_t expected, input aes_block_t actual,
                               inout bit ok);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s %s: expected %0h, actual %0h",
                     name, what, expected, actual);
            errors++;
            ok = 1'b0;
        end
    endtask

    task automatic report_test(input logic [63:0] name, input bit ok);
        tests_run++;
        if (ok)
            $display("test %s passed", name);
        else
        begin
            tests_failed++;
            $display("test %s failed", name);
        end
    endtask

    task automatic load_records();
        for (int i = 0; i < MAX_RECORDS*REC_WORDS; i++)
            rec_mem[i] = '0;
        $readmemh("testbench/aes256_tests.txt", rec_mem);
        while (num_records < MAX_RECORDS && rec_mem[num_records*REC_WORDS] != '0)
        begin
            if (int'(rec_mem[num_records*REC_WORDS+4][15:0]) > max_gap)
                max_gap = int'(rec_mem[num_records*REC_WORDS+4][15:0]);
            num_records++;
        end
        if (num_records == 0)
        begin
            $display("no test records were read from the data file");
            errors++;
        end
    endtask

    // out_valid must stay low with nothing fed since reset.
    task automatic check_idle();
        int pulses;
        bit ok;
        pulses = 0;
        ok = 1'b1;
        repeat (IDLE_CYCLES)
        begin
            @(negedge clk);
            if (out_valid !== 1'b0)
                pulses++;
        end
        check_value("idle_rst", "out_valid pulses", '0, aes_block_t'(pulses), ok);
        report_test("idle_rst", ok);
    endtask

    // a block driven on the falling edge of cycle c is due at cycle c + latency.
    task automatic send_record(input int r);
        int gap;
        int due;
        gap = int'(rec_mem[r*REC_WORDS+4][15:0]);
        if (gap != 0)
            gap = gap + int'($urandom % (EXTRA_GAP_MAX + 1));
        repeat (gap)
        begin
            @(negedge clk);
            in_valid = 1'b0;
        end
        @(negedge clk);
        in_valid  = 1'b1;
        key       = rec_mem[r*REC_WORDS+1];
        plaintext = rec_mem[r*REC_WORDS+2][`AES_BLOCK_W-1:0];
        due       = cyc + `AES_LATENCY;
        @(posedge clk);
        exp_name.push_back(rec_mem[r*REC_WORDS][63:0]);
        exp_ct.push_back(rec_mem[r*REC_WORDS+3][`AES_BLOCK_W-1:0]);
        exp_cyc.push_back(due);
    endtask

    task automatic finish_run();
        int total;
        total = errors + dut0.chk0.assert_fails;
        $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, errors, dut0.chk0.assert_fails);
        if (total == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // result monitor, outputs are stable on the falling edge.
    always @(negedge clk)
    begin
        bit          ok;
        logic [63:0] name;
        int          due;
        if (rst_n === 1'b1 && out_valid !== 1'b0)
        begin
            if (exp_ct.size() == 0)
            begin
                $display("out_valid was high at cycle %0d with no block in flight", cyc);
                errors++;
            end
            else
            begin
                ok   = 1'b1;
                name = exp_name.pop_front();
                due  = exp_cyc.pop_front();
                check_value(name, "ciphertext", exp_ct.pop_front(), ciphertext, ok);
                check_value(name, "output cycle", aes_block_t'(due), aes_block_t'(cyc), ok);
                report_test(name, ok);
                results++;
            end
        end
    end

    initial
    begin
        int seed_init;
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        plaintext = '0;
        key       = '0;
        seed_init = $urandom(32'hb6d126e2);
        load_records();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        check_idle();
        for (int r = 0; r < num_records; r++)
            send_record(r);
        @(negedge clk);
        in_valid = 1'b0;
        wait (results == num_records);
        // keep watching so a stray pulse after the last block is caught.
        repeat (`AES_LATENCY + 2) @(negedge clk);
        finish_run();
    end

    // watchdog.
    initial
    begin
        int limit;
        wait (loaded);
        limit = RESET_CYCLES + IDLE_CYCLES
              + num_records * (max_gap + EXTRA_GAP_MAX + 1)
              + 2 * `AES_LATENCY + 52;
        repeat (limit) @(posedge clk);
        $display("timeout: results never arrived, %0d of %0d blocks came back",
                 results, num_records);
        $display("Errors found");
        $finish;
    end

endmodule

// File: testbench/aes256_chk.sv
/* Assertions on the valid strobe of aes256_core, bound to every instance. */
`timescale 1ns/1ps
`include "aes_params.svh"

module aes256_chk (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic out_valid
);
    int assert_fails = 0;

    // the first reset edge clears the valid line.
    reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !out_valid)
    else
    begin
        $error("out_valid high after a reset cycle");
        assert_fails++;
    end

    valid_follows_input: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, `AES_LATENCY))
    else
    begin
        $error("out_valid does not match in_valid from %0d cycles before", `AES_LATENCY);
        assert_fails++;
    end

    valid_known: assert property (@(posedge clk) rst_n |-> !$isunknown(out_valid))
    else
    begin
        $error("out_valid unknown outside reset");
        assert_fails++;
    end

endmodule

bind aes256_core aes256_chk chk0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid)
);

// File: design/aes256_core.sv
/* Fully pipelined AES-256 encryption, one block per cycle, no back-pressure.
   ciphertext is valid with out_valid, AES_LATENCY cycles after the input edge.
   Only the valid line is reset; data stages carry whatever was last fed. */
`timescale 1ns/1ps
`include "aes_params.svh"

module aes256_core (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  aes_pkg::aes_block_t plaintext,
    input  aes_pkg::aes_key_t   key,
    output logic                out_valid,
    output aes_pkg::aes_block_t ciphertext
);
    import aes_pkg::*;

    aes_block_t              state_init;
    aes_key_t                key_d0;
    aes_key_t                key_d1;
    aes_key_t                key_d2;
    aes_key_t                key_sched [0:`AES_ROUNDS-1];
    aes_block_t              round_key [0:`AES_ROUNDS];
    aes_block_t              state [0:`AES_ROUNDS];
    logic [`AES_LATENCY-1:0] valid_pipe;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // initial key addition and key alignment.
    always_ff @(posedge clk)
    begin
        state_init <= plaintext ^ key[`AES_KEY_W-1 -: `AES_BLOCK_W];
        key_d0     <= key;
        key_d1     <= key_d0;
        key_d2     <= key_d1;
    end

    assign state[0]     = state_init;
    assign round_key[0] = key_d1[`AES_BLOCK_W-1:0];
    assign key_sched[0] = key_d2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // key schedule, even and odd halves in turn.
    for (genvar g = 0; g < `AES_ROUNDS; g++)
    begin : g_key
        localparam aes_rcon_t RCON = aes_rcon_t'(1 << (g / 2));

        if (g < `AES_ROUNDS - 1)
        begin : g_chain
            aes_key_step #(.ODD_HALF(g % 2 == 1)) u_step (
                .clk       (clk),
                .rcon      (RCON),
                .key_in    (key_sched[g]),
                .key_out   (key_sched[g+1]),
                .round_key (round_key[g+1])
            );
        end
        else
        begin : g_last
            // the last step only has to supply the final round key.
            aes_key_step #(.ODD_HALF(g % 2 == 1)) u_step (
                .clk       (clk),
                .rcon      (RCON),
                .key_in    (key_sched[g]),
                .key_out   (),
                .round_key (round_key[g+1])
            );
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // round pipeline.
    for (genvar r = 0; r < `AES_ROUNDS; r++)
    begin : g_round
        aes_round u_round (
            .clk       (clk),
            .state_in  (state[r]),
            .round_key (round_key[r]),
            .state_out (state[r+1])
        );
    end

    aes_final_round u_final (
        .clk       (clk),
        .state_in  (state[`AES_ROUNDS]),
        .round_key (round_key[`AES_ROUNDS]),
        .state_out (ciphertext)
    );

    // valid travels beside the data, one bit per pipeline cycle.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            valid_pipe <= '0;
        else
            valid_pipe <= {valid_pipe[`AES_LATENCY-2:0], in_valid};
    end

    assign out_valid = valid_pipe[`AES_LATENCY-1];

endmodule

// File: design/aes_final_round.sv
/* Last AES round without MixColumns, two cycles deep. */
`timescale 1ns/1ps
`include "aes_params.svh"

module aes_final_round (
    input  logic                clk,
    input  aes_pkg::aes_block_t state_in,
    input  aes_pkg::aes_block_t round_key,
    output aes_pkg::aes_block_t state_out
);
    import aes_pkg::*;

    aes_byte_t  sub [0:15];
    aes_block_t shifted;

    for (genvar i = 0; i < 16; i++)
    begin : g_byte
        aes_sbox u_sbox (
            .clk  (clk),
            .din  (state_in[`AES_BLOCK_W-1-`AES_BYTE_W*i -: `AES_BYTE_W]),
            .dout (sub[i])
        );

        // row i%4 of column i/4 comes from column (i/4 + i%4) mod 4.
        assign shifted[`AES_BLOCK_W-1-`AES_BYTE_W*i -: `AES_BYTE_W] =
            sub[4*((i/4 + i%4) % 4) + i%4];
    end

    always_ff @(posedge clk)
    begin
        state_out <= shifted ^ round_key;
    end

endmodule

// File: design/aes_round.sv
/* One full AES round, two cycles deep: S-box register, then state register.
   MixColumns comes from rotated S-box/xtime lookup words. */
`timescale 1ns/1ps
`include "aes_params.svh"

module aes_round (
    input  logic                clk,
    input  aes_pkg::aes_block_t state_in,
    input  aes_pkg::aes_block_t round_key,
    output aes_pkg::aes_block_t state_out
);
    import aes_pkg::*;

    aes_byte_t  sub [0:15];
    aes_word_t  look [0:15];
    aes_block_t mixed;

    function automatic aes_byte_t xtime(input aes_byte_t b);
        logic [`AES_BYTE_W:0] wide;
        wide = {b, 1'b0};
        if (b[`AES_BYTE_W-1])
            wide = wide ^ `AES_GF_POLY;
        return wide[`AES_BYTE_W-1:0];
    endfunction

    // byte i is column i/4, row i%4.
    for (genvar i = 0; i < 16; i++)
    begin : g_byte
        localparam int SHIFT = `AES_BYTE_W * ((i % 4 + 1) % 4);

        aes_word_t                 base;
        logic [2*`AES_WORD_W-1:0]  twice;

        aes_sbox u_sbox (
            .clk  (clk),
            .din  (state_in[`AES_BLOCK_W-1-`AES_BYTE_W*i -: `AES_BYTE_W]),
            .dout (sub[i])
        );

        // {s, s, 3s, 2s}, rotated so each row lands on its MixColumns weights.
        assign base    = {sub[i], sub[i], sub[i] ^ xtime(sub[i]), xtime(sub[i])};
        assign twice   = {base, base};
        assign look[i] = twice[SHIFT +: `AES_WORD_W];
    end

    // ShiftRows picks row r of output column c from column c+r.
    for (genvar c = 0; c < 4; c++)
    begin : g_col
        assign mixed[`AES_BLOCK_W-1-`AES_WORD_W*c -: `AES_WORD_W] =
            look[4*c]
            ^ look[4*((c+1)%4) + 1]
            ^ look[4*((c+2)%4) + 2]
            ^ look[4*((c+3)%4) + 3]
            ^ round_key[`AES_BLOCK_W-1-`AES_WORD_W*c -: `AES_WORD_W];
    end

    always_ff @(posedge clk)
    begin
        state_out <= mixed;
    end

endmodule

// File: design/aes_key_step.sv
/* One on-the-fly AES-256 key expansion step, two cycles deep.
   ODD_HALF 0 makes words 0-3 with RotWord and rcon, 1 makes words 4-7 with
   SubWord only. round_key is combinational from the internal register. */
`timescale 1ns/1ps
`include "aes_params.svh"

module aes_key_step #(
    parameter bit ODD_HALF = 1'b0
) (
    input  logic                clk,
    input  aes_pkg::aes_rcon_t  rcon,
    input  aes_pkg::aes_key_t   key_in,
    output aes_pkg::aes_key_t   key_out,
    output aes_pkg::aes_block_t round_key
);
    import aes_pkg::*;

    localparam int WORDS = `AES_BLOCK_W / `AES_WORD_W;

    aes_block_t upd_half;
    aes_block_t keep_half;
    aes_word_t  upd_w0;
    aes_word_t  sub_src;
    aes_word_t  sub_word;
    aes_block_t prefix;
    aes_block_t prefix_q;
    aes_block_t keep_q;
    aes_block_t fresh;

    if (ODD_HALF == 1'b0)
    begin : g_even
        // w[i] from w[i-8] and the rotated last word.
        assign upd_half  = key_in[`AES_KEY_W-1 -: `AES_BLOCK_W];
        assign keep_half = key_in[`AES_BLOCK_W-1:0];
        assign sub_src   = {key_in[`AES_WORD_W-`AES_BYTE_W-1:0],
                            key_in[`AES_WORD_W-1 -: `AES_BYTE_W]};
        assign upd_w0    = upd_half[`AES_BLOCK_W-1 -: `AES_WORD_W]
                         ^ {rcon, {(`AES_WORD_W-`AES_BYTE_W){1'b0}}};
    end
    else
    begin : g_odd
        // word 3 feeds SubWord with no rotation and no rcon.
        assign upd_half  = key_in[`AES_BLOCK_W-1:0];
        assign keep_half = key_in[`AES_KEY_W-1 -: `AES_BLOCK_W];
        assign sub_src   = key_in[`AES_BLOCK_W +: `AES_WORD_W];
        assign upd_w0    = upd_half[`AES_BLOCK_W-1 -: `AES_WORD_W];
    end

    // running XOR over the half, the substituted word joins after the register.
    always_comb
    begin
        prefix[`AES_BLOCK_W-1 -: `AES_WORD_W] = upd_w0;
        for (int j = 1; j < WORDS; j++)
        begin
            prefix[`AES_BLOCK_W-1-`AES_WORD_W*j -: `AES_WORD_W] =
                prefix[`AES_BLOCK_W-1-`AES_WORD_W*(j-1) -: `AES_WORD_W]
                ^ upd_half[`AES_BLOCK_W-1-`AES_WORD_W*j -: `AES_WORD_W];
        end
    end

    for (genvar b = 0; b < `AES_WORD_W / `AES_BYTE_W; b++)
    begin : g_sub
        aes_sbox u_sbox (
            .clk  (clk),
            .din  (sub_src[`AES_BYTE_W*b +: `AES_BYTE_W]),
            .dout (sub_word[`AES_BYTE_W*b +: `AES_BYTE_W])
        );
    end

    assign fresh     = prefix_q ^ {WORDS{sub_word}};
    assign round_key = fresh;

    always_ff @(posedge clk)
    begin
        prefix_q <= prefix;
        keep_q   <= keep_half;
        if (ODD_HALF == 1'b0)
            key_out <= {fresh, keep_q};
        else
            key_out <= {keep_q, fresh};
    end

endmodule

// File: design/aes_sbox.sv
/* Forward AES S-box as a composite-field gate network, no lookup table.
   The output is registered, so dout trails din by one cycle. */
`timescale 1ns/1ps

module aes_sbox (
    input  logic               clk,
    input  aes_pkg::aes_byte_t din,
    output aes_pkg::aes_byte_t dout
);
    import aes_pkg::*;

    // bit 0 is the most significant bit in this network.
    logic [0:7]  x;
    logic [0:7]  s;
    logic [21:1] y;
    logic [67:0] t;
    logic [17:0] z;
    aes_byte_t   res;

    always_comb
    begin
        x = din;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // top linear layer.
        y[14] = x[3] ^ x[5];
        y[13] = x[0] ^ x[6];
        y[9]  = x[0] ^ x[3];
        y[8]  = x[0] ^ x[5];
        t[0]  = x[1] ^ x[2];
        y[1]  = t[0] ^ x[7];
        y[4]  = y[1] ^ x[3];
        y[12] = y[13] ^ y[14];
        y[2]  = y[1] ^ x[0];
        y[5]  = y[1] ^ x[6];
        y[3]  = y[5] ^ y[8];
        t[1]  = x[4] ^ y[12];
        y[15] = t[1] ^ x[5];
        y[20] = t[1] ^ x[1];
        y[6]  = y[15] ^ x[7];
        y[10] = y[15] ^ t[0];
        y[11] = y[20] ^ y[9];
        y[7]  = x[7] ^ y[11];
        y[17] = y[10] ^ y[11];
        y[19] = y[10] ^ y[8];
        y[16] = t[0] ^ y[11];
        y[21] = y[13] ^ y[16];
        y[18] = x[0] ^ y[16];

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // nonlinear core, inversion in GF(2^4) squared.
        t[2]  = y[12] & y[15];
        t[3]  = y[3] & y[6];
        t[4]  = t[3] ^ t[2];
        t[5]  = y[4] & x[7];
        t[6]  = t[5] ^ t[2];
        t[7]  = y[13] & y[16];
        t[8]  = y[5] & y[1];
        t[9]  = t[8] ^ t[7];
        t[10] = y[2] & y[7];
        t[11] = t[10] ^ t[7];
        t[12] = y[9] & y[11];
        t[13] = y[14] & y[17];
        t[14] = t[13] ^ t[12];
        t[15] = y[8] & y[10];
        t[16] = t[15] ^ t[12];
        t[17] = t[4] ^ t[14];
        t[18] = t[6] ^ t[16];
        t[19] = t[9] ^ t[14];
        t[20] = t[11] ^ t[16];
        t[21] = t[17] ^ y[20];
        t[22] = t[18] ^ y[19];
        t[23] = t[19] ^ y[21];
        t[24] = t[20] ^ y[18];

        // the GF(2^4) inverse itself.
        t[25] = t[21] ^ t[22];
        t[26] = t[21] & t[23];
        t[27] = t[24] ^ t[26];
        t[28] = t[25] & t[27];
        t[29] = t[28] ^ t[22];
        t[30] = t[23] ^ t[24];
        t[31] = t[22] ^ t[26];
        t[32] = t[31] & t[30];
        t[33] = t[32] ^ t[24];
        t[34] = t[23] ^ t[33];
        t[35] = t[27] ^ t[33];
        t[36] = t[24] & t[35];
        t[37] = t[36] ^ t[34];
        t[38] = t[27] ^ t[36];
        t[39] = t[29] & t[38];
        t[40] = t[25] ^ t[39];
        t[41] = t[40] ^ t[37];
        t[42] = t[29] ^ t[33];
        t[43] = t[29] ^ t[40];
        t[44] = t[33] ^ t[37];
        t[45] = t[42] ^ t[41];

        z[0]  = t[44] & y[15];
        z[1]  = t[37] & y[6];
        z[2]  = t[33] & x[7];
        z[3]  = t[43] & y[16];
        z[4]  = t[40] & y[1];
        z[5]  = t[29] & y[7];
        z[6]  = t[42] & y[11];
        z[7]  = t[45] & y[17];
        z[8]  = t[41] & y[10];
        z[9]  = t[44] & y[12];
        z[10] = t[37] & y[3];
        z[11] = t[33] & y[4];
        z[12] = t[43] & y[13];
        z[13] = t[40] & y[5];
        z[14] = t[29] & y[2];
        z[15] = t[42] & y[9];
        z[16] = t[45] & y[14];
        z[17] = t[41] & y[8];

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // bottom linear layer, affine constant folded into the inversions.
        t[46] = z[15] ^ z[16];
        t[47] = z[10] ^ z[11];
        t[48] = z[5] ^ z[13];
        t[49] = z[9] ^ z[10];
        t[50] = z[2] ^ z[12];
        t[51] = z[2] ^ z[5];
        t[52] = z[7] ^ z[8];
        t[53] = z[0] ^ z[3];
        t[54] = z[6] ^ z[7];
        t[55] = z[16] ^ z[17];
        t[56] = z[12] ^ t[48];
        t[57] = t[50] ^ t[53];
        t[58] = z[4] ^ t[46];
        t[59] = z[3] ^ t[54];
        t[60] = t[46] ^ t[57];
        t[61] = z[14] ^ t[57];
        t[62] = t[52] ^ t[58];
        t[63] = t[49] ^ t[58];
        t[64] = z[4] ^ t[59];
        t[65] = t[61] ^ t[62];
        t[66] = z[1] ^ t[63];
        t[67] = t[64] ^ t[65];

        s[0] = t[59] ^ t[63];
        s[3] = t[53] ^ t[66];
        s[4] = t[51] ^ t[66];
        s[5] = t[47] ^ t[65];
        s[6] = ~t[56] ^ t[62];
        s[7] = ~t[48] ^ t[60];
        s[1] = ~t[64] ^ s[3];
        s[2] = ~t[55] ^ t[67];

        res = s;
    end

    always_ff @(posedge clk)
    begin
        dout <= res;
    end

endmodule

// File: design/aes_pkg.sv
/* Vector types of the AES-256 core. Widths come from aes_params.svh. */
`include "aes_params.svh"

package aes_pkg;

    // one state byte.
    typedef logic [`AES_BYTE_W-1:0] aes_byte_t;

    // one state column or key-schedule word.
    typedef logic [`AES_WORD_W-1:0] aes_word_t;

    // full state, also used for a round key.
    typedef logic [`AES_BLOCK_W-1:0] aes_block_t;

    // cipher key and the running key-schedule register.
    typedef logic [`AES_KEY_W-1:0] aes_key_t;

    // round constant, applied to the top byte of the first word.
    typedef logic [`AES_BYTE_W-1:0] aes_rcon_t;

endpackage

// File: design/aes_params.svh
/* Widths, round count and pipeline latency of the AES-256 core.
   AES_LATENCY must stay 1 + 2 * AES_ROUNDS + 2 if the stage timing changes. */
`ifndef AES_PARAMS_SVH
`define AES_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vector widths.
`define AES_BYTE_W   8
`define AES_WORD_W   32
`define AES_BLOCK_W  128
`define AES_KEY_W    256

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// round structure and timing.
`define AES_ROUNDS   13
`define AES_LATENCY  29

// x^8 + x^4 + x^3 + x + 1.
`define AES_GF_POLY  9'h11b

`endif
